// File: hw/l2_pkg.sv
// L2 cache shared types
package l2_pkg;

    localparam int ADDR_W     = 32;
    localparam int LINE_BYTES = 16;
    localparam int OFFS_W     = $clog2(LINE_BYTES);
    localparam int LINE_W     = LINE_BYTES * 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [31:0]       iword_t;

    // Data accesses are 8-byte aligned
    typedef logic [63:0]       dword_t;

    typedef enum logic [2:0] {
        READY,
        FETCH_I,
        LOAD_I,
        FETCH_D,
        LOAD_D,
        WRITE
    } l2_state_e;

endpackage

// File: hw/l2_tag_array.sv
// L2 tag and valid storage
module l2_tag_array
    import l2_pkg::*;
#(
    parameter int  SETS  = 16,
    parameter int  WAYS  = 4,
    localparam int SET_W = $clog2(SETS),
    localparam int WAY_W = $clog2(WAYS),
    localparam int TAG_W = ADDR_W - SET_W - OFFS_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  addr_t            i_addr_i,
    input  addr_t            d_addr_i,
    input  logic             wr_en_i,
    input  logic [SET_W-1:0] wr_set_i,
    input  logic [WAY_W-1:0] wr_way_i,
    input  logic [TAG_W-1:0] wr_tag_i,
    output logic             i_hit_o,
    output logic [WAY_W-1:0] i_way_o,
    output logic             d_hit_o,
    output logic [WAY_W-1:0] d_way_o
);

    logic [TAG_W-1:0] tags_q  [SETS][WAYS];
    logic [WAYS-1:0]  valid_q [SETS];

    // Returns {hit, way} for one address
    function automatic logic [WAY_W:0] lookup(input addr_t addr);
        logic [SET_W-1:0] s_idx;
        logic [TAG_W-1:0] tag;
        logic [WAY_W:0]   res;
        s_idx = addr[OFFS_W +: SET_W];
        tag   = addr[ADDR_W-1 -: TAG_W];
        res   = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_q[s_idx][w] && tags_q[s_idx][w] == tag) begin
                res = {1'b1, WAY_W'(w)};
            end
        end
        return res;
    endfunction

    always_comb begin
        {i_hit_o, i_way_o} = lookup(i_addr_i);
        {d_hit_o, d_way_o} = lookup(d_addr_i);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (wr_en_i) begin
            valid_q[wr_set_i][wr_way_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tags_q[wr_set_i][wr_way_i] <= wr_tag_i;
        end
    end

endmodule

// File: hw/l2_data_array.sv
// L2 line storage
module l2_data_array
    import l2_pkg::*;
#(
    parameter int  SETS  = 16,
    parameter int  WAYS  = 4,
    localparam int SET_W = $clog2(SETS),
    localparam int WAY_W = $clog2(WAYS),
    localparam int IDX_W = SET_W + WAY_W
) (
    input  logic             clk,
    input  logic             rd_en_i,
    input  logic [IDX_W-1:0] rd_idx_i,
    input  logic             wr_en_i,
    input  logic [SET_W-1:0] wr_set_i,
    input  logic [WAY_W-1:0] wr_way_i,
    input  line_t            wr_line_i,
    output line_t            rd_line_o
);

    // Entry index is set * WAYS + way
    line_t mem [SETS*WAYS];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[{wr_set_i, wr_way_i}] <= wr_line_i;
        end
        if (rd_en_i) begin
            rd_line_o <= mem[rd_idx_i];
        end
    end

endmodule

// File: hw/l2_plru.sv
// Tree pseudo-LRU replacement
module l2_plru #(
    parameter int  SETS  = 16,
    parameter int  WAYS  = 4,
    localparam int SET_W = $clog2(SETS),
    localparam int WAY_W = $clog2(WAYS)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             touch_i,
    input  logic [SET_W-1:0] touch_set_i,
    input  logic [WAY_W-1:0] touch_way_i,
    input  logic [SET_W-1:0] query_set_i,
    output logic [WAY_W-1:0] victim_way_o
);

    // Heap-ordered nodes, children of n are 2n+1 and 2n+2.
    // Level l decides way bit l, and a set node bit steers to the 2n+1 child.
    logic [WAYS-2:0] tree_q [SETS];
    logic [WAYS-2:0] touched;

    // Point every node on the path away from the touched way
    always_comb begin : touch_path
        int node;
        touched = tree_q[touch_set_i];
        node    = 0;
        for (int l = 0; l < WAY_W; l++) begin
            touched[node] = touch_way_i[l];
            node          = 2 * node + 1 + int'(touch_way_i[l]);
        end
    end

    always_comb begin : victim_walk
        int node;
        victim_way_o = '0;
        node         = 0;
        for (int l = 0; l < WAY_W; l++) begin
            victim_way_o[l] = ~tree_q[query_set_i][node];
            node            = 2 * node + 1 + int'(victim_way_o[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '1;
            end
        end else if (touch_i) begin
            tree_q[touch_set_i] <= touched;
        end
    end

endmodule

// File: hw/l2_line_buf.sv
// Single line buffer for one core port
module l2_line_buf
    import l2_pkg::*;
#(
    parameter type word_t = iword_t
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load_i,
    input  addr_t load_addr_i,
    input  line_t load_line_i,
    input  addr_t addr_i,
    output logic  hit_o,
    output word_t word_o,
    output line_t line_o
);

    localparam int WORD_W   = $bits(word_t);
    localparam int WORD_LSB = $clog2(WORD_W / 8);

    logic                     valid_q;
    logic [ADDR_W-1:OFFS_W]   line_addr_q;
    line_t                    line_q;
    logic [OFFS_W-1:WORD_LSB] word_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            line_addr_q <= load_addr_i[ADDR_W-1:OFFS_W];
            line_q      <= load_line_i;
        end
    end

    assign hit_o    = valid_q && line_addr_q == addr_i[ADDR_W-1:OFFS_W];
    assign word_idx = addr_i[OFFS_W-1:WORD_LSB];
    // Zero when the buffer does not hold the addressed line
    assign word_o   = hit_o ? line_q[int'(word_idx) * WORD_W +: WORD_W] : '0;
    assign line_o   = line_q;

endmodule

// File: hw/l2_ctrl.sv
// L2 cache controller
module l2_ctrl
    import l2_pkg::*;
#(
    parameter int  SETS  = 16,
    parameter int  WAYS  = 4,
    localparam int SET_W = $clog2(SETS),
    localparam int WAY_W = $clog2(WAYS),
    localparam int TAG_W = ADDR_W - SET_W - OFFS_W,
    localparam int IDX_W = SET_W + WAY_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_rd_i,
    input  addr_t            i_addr_i,
    input  logic             d_rd_i,
    input  logic             d_wr_i,
    input  addr_t            d_addr_i,
    input  dword_t           d_wdata_i,
    input  logic             i_buf_hit_i,
    input  logic             d_buf_hit_i,
    input  logic             i_tag_hit_i,
    input  logic [WAY_W-1:0] i_hit_way_i,
    input  logic             d_tag_hit_i,
    input  logic [WAY_W-1:0] d_hit_way_i,
    input  logic [WAY_W-1:0] victim_way_i,
    input  logic             mem_dv_i,
    input  line_t            mem_rdata_i,
    input  line_t            rd_line_i,
    input  line_t            d_buf_line_i,
    output logic             stall_o,
    output addr_t            mem_addr_o,
    output logic             mem_rd_o,
    output logic             mem_wr_o,
    output line_t            mem_wdata_o,
    output logic             arr_rd_en_o,
    output logic [IDX_W-1:0] arr_rd_idx_o,
    output logic             arr_wr_en_o,
    output logic [SET_W-1:0] arr_wr_set_o,
    output logic [WAY_W-1:0] arr_wr_way_o,
    output line_t            arr_wr_line_o,
    output logic             tag_wr_en_o,
    output logic [SET_W-1:0] tag_wr_set_o,
    output logic [WAY_W-1:0] tag_wr_way_o,
    output logic [TAG_W-1:0] tag_wr_tag_o,
    output logic             lru_touch_o,
    output logic [SET_W-1:0] lru_set_o,
    output logic [WAY_W-1:0] lru_way_o,
    output logic             i_buf_load_o,
    output logic             d_buf_load_o,
    output line_t            buf_line_o,
    output addr_t            buf_addr_o
);

    localparam int DWORD_W  = $bits(dword_t);
    localparam int DWORD_LSB = $clog2(DWORD_W / 8);

    l2_state_e        state_q;
    l2_state_e        state_d;
    logic             wr_done_q;
    logic [WAY_W-1:0] way_q;

    logic             i_miss;
    logic             d_rd_miss;
    logic             d_wr_pend;
    logic             use_i;
    logic             go;
    logic             tag_hit;
    logic             fetch;
    logic             fill;
    logic [WAY_W-1:0] hit_way;
    logic [WAY_W-1:0] sel_way;
    addr_t            act_addr;
    addr_t            line_addr;
    logic [SET_W-1:0] act_set;
    line_t            merged;

    assign i_miss    = i_rd_i && !i_buf_hit_i;
    assign d_rd_miss = d_rd_i && !d_buf_hit_i;
    // A write stays pending until the cycle after WRITE
    assign d_wr_pend = d_wr_i && !wr_done_q;
    assign stall_o   = d_rd_miss || d_wr_pend;

    // Instruction misses win arbitration in READY
    assign use_i     = (state_q == READY) ? i_miss
                     : (state_q == FETCH_I || state_q == LOAD_I);
    assign go        = state_q == READY && (i_miss || d_rd_miss || d_wr_pend);
    assign act_addr  = use_i ? i_addr_i : d_addr_i;
    assign line_addr = {act_addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    assign act_set   = act_addr[OFFS_W +: SET_W];
    assign tag_hit   = use_i ? i_tag_hit_i : d_tag_hit_i;
    assign hit_way   = use_i ? i_hit_way_i : d_hit_way_i;
    assign sel_way   = tag_hit ? hit_way : victim_way_i;
    assign fetch     = state_q == FETCH_I || state_q == FETCH_D;
    assign fill      = fetch && mem_dv_i;

    // Pending data word merged into the buffered line
    always_comb begin
        merged = d_buf_line_i;
        merged[int'(d_addr_i[OFFS_W-1:DWORD_LSB]) * DWORD_W +: DWORD_W] = d_wdata_i;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            READY: begin
                if (i_miss) begin
                    state_d = i_tag_hit_i ? LOAD_I : FETCH_I;
                end else if (d_rd_miss || d_wr_pend) begin
                    state_d = d_tag_hit_i ? LOAD_D : FETCH_D;
                end
            end
            FETCH_I: begin
                if (mem_dv_i) begin
                    state_d = READY;
                end
            end
            FETCH_D: begin
                if (mem_dv_i) begin
                    state_d = d_wr_i ? WRITE : READY;
                end
            end
            LOAD_I:  state_d = READY;
            LOAD_D:  state_d = d_wr_i ? WRITE : READY;
            default: state_d = READY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= READY;
            wr_done_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            wr_done_q <= state_q == WRITE;
        end
    end

    // Way chosen at lookup, kept for the fill and the merge
    always_ff @(posedge clk) begin
        if (go) begin
            way_q <= sel_way;
        end
    end

    assign mem_addr_o    = line_addr;
    assign mem_rd_o      = fetch;
    assign mem_wr_o      = state_q == WRITE;
    assign mem_wdata_o   = merged;

    // Hit lookups read the array while still in READY
    assign arr_rd_en_o   = go && tag_hit;
    assign arr_rd_idx_o  = {act_set, hit_way};
    assign arr_wr_en_o   = fill || state_q == WRITE;
    assign arr_wr_set_o  = act_set;
    assign arr_wr_way_o  = way_q;
    assign arr_wr_line_o = (state_q == WRITE) ? merged : mem_rdata_i;

    assign tag_wr_en_o   = fill;
    assign tag_wr_set_o  = act_set;
    assign tag_wr_way_o  = way_q;
    assign tag_wr_tag_o  = act_addr[ADDR_W-1 -: TAG_W];

    assign lru_touch_o   = go;
    assign lru_set_o     = act_set;
    assign lru_way_o     = sel_way;

    // The instruction copy takes the merged line too, so it never goes stale
    assign i_buf_load_o  = (fill && state_q == FETCH_I) || state_q == LOAD_I
                         || state_q == WRITE;
    assign d_buf_load_o  = (fill && state_q == FETCH_D) || state_q == LOAD_D
                         || state_q == WRITE;
    assign buf_line_o    = (state_q == WRITE) ? merged : fetch ? mem_rdata_i : rd_line_i;
    assign buf_addr_o    = line_addr;

endmodule

// File: hw/hart_l2.sv
// Hart L2 cache top level
module hart_l2
    import l2_pkg::*;
#(
    parameter int SETS = 16,
    parameter int WAYS = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   i_rd_i,
    input  addr_t  i_addr_i,
    output iword_t i_data_o,
    output logic   i_dv_o,
    input  logic   d_rd_i,
    input  logic   d_wr_i,
    input  addr_t  d_addr_i,
    input  dword_t d_wdata_i,
    output dword_t d_data_o,
    output logic   d_dv_o,
    output logic   stall_o,
    output addr_t  mem_addr_o,
    output logic   mem_rd_o,
    input  logic   mem_dv_i,
    input  line_t  mem_rdata_i,
    output logic   mem_wr_o,
    output line_t  mem_wdata_o
);

    localparam int SET_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);
    localparam int TAG_W = ADDR_W - SET_W - OFFS_W;

    logic i_buf_hit;
    logic d_buf_hit;
    logic i_tag_hit;
    logic d_tag_hit;
    logic [WAY_W-1:0] i_hit_way;
    logic [WAY_W-1:0] d_hit_way;
    logic [WAY_W-1:0] victim_way;
    line_t rd_line;
    line_t d_buf_line;
    logic arr_rd_en;
    logic [SET_W+WAY_W-1:0] arr_rd_idx;
    logic arr_wr_en;
    logic [SET_W-1:0] arr_wr_set;
    logic [WAY_W-1:0] arr_wr_way;
    line_t arr_wr_line;
    logic tag_wr_en;
    logic [SET_W-1:0] tag_wr_set;
    logic [WAY_W-1:0] tag_wr_way;
    logic [TAG_W-1:0] tag_wr_tag;
    logic lru_touch;
    logic [SET_W-1:0] lru_set;
    logic [WAY_W-1:0] lru_way;
    logic i_buf_load;
    logic d_buf_load;
    line_t buf_line;
    addr_t buf_addr;

    assign i_dv_o = i_buf_hit && i_rd_i;
    assign d_dv_o = d_buf_hit && d_rd_i;

    l2_ctrl #(.SETS(SETS), .WAYS(WAYS)) u_ctrl (
        .clk, .rst_n, .i_rd_i, .i_addr_i, .d_rd_i, .d_wr_i, .d_addr_i, .d_wdata_i,
        .i_buf_hit_i(i_buf_hit), .d_buf_hit_i(d_buf_hit),
        .i_tag_hit_i(i_tag_hit), .i_hit_way_i(i_hit_way),
        .d_tag_hit_i(d_tag_hit), .d_hit_way_i(d_hit_way),
        .victim_way_i(victim_way), .mem_dv_i, .mem_rdata_i,
        .rd_line_i(rd_line), .d_buf_line_i(d_buf_line),
        .stall_o, .mem_addr_o, .mem_rd_o, .mem_wr_o, .mem_wdata_o,
        .arr_rd_en_o(arr_rd_en), .arr_rd_idx_o(arr_rd_idx),
        .arr_wr_en_o(arr_wr_en), .arr_wr_set_o(arr_wr_set),
        .arr_wr_way_o(arr_wr_way), .arr_wr_line_o(arr_wr_line),
        .tag_wr_en_o(tag_wr_en), .tag_wr_set_o(tag_wr_set),
        .tag_wr_way_o(tag_wr_way), .tag_wr_tag_o(tag_wr_tag),
        .lru_touch_o(lru_touch), .lru_set_o(lru_set), .lru_way_o(lru_way),
        .i_buf_load_o(i_buf_load), .d_buf_load_o(d_buf_load),
        .buf_line_o(buf_line), .buf_addr_o(buf_addr)
    );

    l2_tag_array #(.SETS(SETS), .WAYS(WAYS)) u_tag_array (
        .clk, .rst_n, .i_addr_i, .d_addr_i,
        .wr_en_i(tag_wr_en), .wr_set_i(tag_wr_set),
        .wr_way_i(tag_wr_way), .wr_tag_i(tag_wr_tag),
        .i_hit_o(i_tag_hit), .i_way_o(i_hit_way),
        .d_hit_o(d_tag_hit), .d_way_o(d_hit_way)
    );

    l2_data_array #(.SETS(SETS), .WAYS(WAYS)) u_data_array (
        .clk, .rd_en_i(arr_rd_en), .rd_idx_i(arr_rd_idx),
        .wr_en_i(arr_wr_en), .wr_set_i(arr_wr_set),
        .wr_way_i(arr_wr_way), .wr_line_i(arr_wr_line),
        .rd_line_o(rd_line)
    );

    // The lookup set also selects the victim
    l2_plru #(.SETS(SETS), .WAYS(WAYS)) u_plru (
        .clk, .rst_n, .touch_i(lru_touch), .touch_set_i(lru_set),
        .touch_way_i(lru_way), .query_set_i(lru_set),
        .victim_way_o(victim_way)
    );

    l2_line_buf #(.word_t(iword_t)) u_i_buf (
        .clk, .rst_n, .load_i(i_buf_load), .load_addr_i(buf_addr),
        .load_line_i(buf_line), .addr_i(i_addr_i),
        .hit_o(i_buf_hit), .word_o(i_data_o), .line_o()
    );

    l2_line_buf #(.word_t(dword_t)) u_d_buf (
        .clk, .rst_n, .load_i(d_buf_load), .load_addr_i(buf_addr),
        .load_line_i(buf_line), .addr_i(d_addr_i),
        .hit_o(d_buf_hit), .word_o(d_data_o), .line_o(d_buf_line)
    );

endmodule

// File: tb/tb_clk_gen.sv
// Testbench clock source
module tb_clk_gen #(
    parameter int PERIOD = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

// File: tb/tb_hart_l2.sv
// Hart L2 cache testbench
module tb_hart_l2
    import l2_pkg::*;
();

    localparam int SETS      = 4;
    localparam int WAYS      = 4;
    localparam int MEM_WORDS = 256;
    localparam int N_RAND    = 60;
    // Thirteen directed requests and at most two per random step
    localparam int N_REQ     = 13 + 2 * N_RAND;
    localparam int TIMEOUT   = 200 * N_REQ;

    logic   clk;
    logic   rst_n;
    logic   i_rd_i;
    addr_t  i_addr_i;
    iword_t i_data_o;
    logic   i_dv_o;
    logic   d_rd_i;
    logic   d_wr_i;
    addr_t  d_addr_i;
    dword_t d_wdata_i;
    dword_t d_data_o;
    logic   d_dv_o;
    logic   stall_o;
    addr_t  mem_addr_o;
    logic   mem_rd_o;
    logic   mem_dv_i;
    line_t  mem_rdata_i;
    logic   mem_wr_o;
    line_t  mem_wdata_o;

    // Bus memory and the reference image in little endian words
    logic [31:0] mem_words [MEM_WORDS];
    logic [31:0] ref_words [MEM_WORDS];

    int    errors   = 0;
    int    n_checks = 0;
    int    rd_count = 0;
    int    wr_count = 0;
    int    cycles   = 0;
    line_t last_wr_line;
    addr_t last_wr_addr;

    tb_clk_gen #(.PERIOD(4)) u_clk_gen (.clk_o(clk));

    hart_l2 #(.SETS(SETS), .WAYS(WAYS)) u_hart_l2 (.*);

    function automatic line_t ref_line(input addr_t addr);
        logic [7:0] base;
        base = {addr[9:4], 2'b00};
        return {ref_words[base + 8'd3], ref_words[base + 8'd2],
                ref_words[base + 8'd1], ref_words[base]};
    endfunction

    // Instruction words come back zero extended
    function automatic logic [63:0] ref_word(input bit inst, input addr_t addr);
        logic [7:0] idx;
        idx = addr[9:2];
        if (inst) begin
            return {32'h0, ref_words[idx]};
        end
        return {ref_words[idx + 8'd1], ref_words[idx]};
    endfunction

    task automatic check_eq(input string name, input logic [127:0] expected,
                            input logic [127:0] actual);
        n_checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Holds a read until its valid rises and reports the cycles waited
    task automatic read_word(input bit inst, input addr_t addr, input string name,
                             output int waited);
        logic [63:0] got;
        waited = 0;
        if (inst) begin
            i_rd_i   = 1'b1;
            i_addr_i = addr;
        end else begin
            d_rd_i   = 1'b1;
            d_addr_i = addr;
        end
        @(negedge clk);
        while (!(inst ? i_dv_o : d_dv_o)) begin
            // Only a data read that misses its buffer stalls
            check_eq($sformatf("%s stall", name), 128'(!inst), 128'(stall_o));
            waited++;
            @(negedge clk);
        end
        check_eq($sformatf("%s stall", name), '0, 128'(stall_o));
        got = inst ? {32'h0, i_data_o} : d_data_o;
        check_eq(name, 128'(ref_word(inst, addr)), 128'(got));
        @(posedge clk);
        #1;
        i_rd_i = 1'b0;
        d_rd_i = 1'b0;
    endtask

    task automatic write_word(input addr_t addr, input dword_t data);
        int         wr_before;
        logic [7:0] idx;
        wr_before             = wr_count;
        idx                   = addr[9:2];
        ref_words[idx]        = data[31:0];
        ref_words[idx + 8'd1] = data[63:32];
        d_wr_i                = 1'b1;
        d_addr_i              = addr;
        d_wdata_i             = data;
        @(negedge clk);
        while (stall_o) begin
            @(negedge clk);
        end
        check_eq($sformatf("write count %h", addr), 128'(wr_before + 1), 128'(wr_count));
        check_eq($sformatf("write line %h", addr), ref_line(addr), last_wr_line);
        check_eq($sformatf("write addr %h", addr), 128'({addr[31:4], 4'h0}),
                 128'(last_wr_addr));
        @(posedge clk);
        #1;
        d_wr_i = 1'b0;
    endtask

    // Reads answered after 1 to 4 cycles and write-through lines applied
    always begin : mem_model
        int         delay;
        logic [7:0] base;
        @(negedge clk);
        base = {mem_addr_o[9:4], 2'b00};
        if (mem_wr_o) begin
            mem_words[base]        = mem_wdata_o[31:0];
            mem_words[base + 8'd1] = mem_wdata_o[63:32];
            mem_words[base + 8'd2] = mem_wdata_o[95:64];
            mem_words[base + 8'd3] = mem_wdata_o[127:96];
            last_wr_line           = mem_wdata_o;
            last_wr_addr           = mem_addr_o;
            wr_count++;
        end
        if (mem_rd_o) begin
            delay = 1 + int'($urandom % 4);
            repeat (delay) @(posedge clk);
            #1;
            mem_dv_i    = 1'b1;
            mem_rdata_i = {mem_words[base + 8'd3], mem_words[base + 8'd2],
                           mem_words[base + 8'd1], mem_words[base]};
            rd_count++;
            @(posedge clk);
            #1;
            mem_dv_i = 1'b0;
        end
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, a request was never served", cycles);
            $display("Checks: %0d, errors: %0d", n_checks, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        int          waited;
        int          rd_before;
        int          n_writes;
        int          kind;
        addr_t       addr;
        dword_t      wdata;
        logic [31:0] w;
        void'($urandom(32'hc2fa_3110));
        rst_n       = 1'b0;
        i_rd_i      = 1'b0;
        i_addr_i    = '0;
        d_rd_i      = 1'b0;
        d_wr_i      = 1'b0;
        d_addr_i    = '0;
        d_wdata_i   = '0;
        mem_dv_i    = 1'b0;
        mem_rdata_i = '0;
        for (int k = 0; k < MEM_WORDS; k++) begin
            w            = $urandom;
            mem_words[k] = w;
            ref_words[k] = w;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_eq("reset mem_rd_o", '0, 128'(mem_rd_o));
        check_eq("reset mem_wr_o", '0, 128'(mem_wr_o));
        check_eq("reset i_dv_o", '0, 128'(i_dv_o));
        check_eq("reset d_dv_o", '0, 128'(d_dv_o));
        @(posedge clk);
        #1;

        // Lines A to E of set 3 where E takes the way of A
        for (int k = 0; k < 5; k++) begin
            rd_before = rd_count;
            addr      = 32'h030 + 32'(k) * 32'h40;
            read_word(1'b0, addr, $sformatf("fill read %h", addr), waited);
            check_eq($sformatf("fill fetch %h", addr), 128'(rd_before + 1), 128'(rd_count));
        end
        rd_before = rd_count;
        read_word(1'b0, 32'h078, "reread B", waited);
        check_eq("B fetch count", 128'(rd_before), 128'(rd_count));
        read_word(1'b0, 32'h030, "reread A", waited);
        check_eq("A fetch count", 128'(rd_before + 1), 128'(rd_count));

        // One fill then a buffer hit and a lookup hit on the other port
        rd_before = rd_count;
        read_word(1'b0, 32'h048, "line fill", waited);
        read_word(1'b0, 32'h040, "buffer reread", waited);
        check_eq("buffer reread latency", '0, 128'(waited));
        read_word(1'b1, 32'h04c, "lookup hit", waited);
        check_eq("lookup hit latency", 128'(2), 128'(waited));
        check_eq("reread fetch count", 128'(rd_before + 1), 128'(rd_count));

        wdata = {$urandom, $urandom};
        write_word(32'h048, wdata);
        n_writes = 1;
        read_word(1'b0, 32'h048, "write readback", waited);
        read_word(1'b1, 32'h04c, "write readback inst", waited);

        for (int n = 0; n < N_RAND; n++) begin
            kind = int'($urandom % 4);
            addr = $urandom % 32'h200;
            if (kind == 0) begin
                addr[2:0] = 3'b000;
                wdata     = {$urandom, $urandom};
                write_word(addr, wdata);
                n_writes++;
                read_word(1'b0, addr, $sformatf("rand readback %h", addr), waited);
            end else if (kind == 1) begin
                addr[2:0] = 3'b000;
                read_word(1'b0, addr, $sformatf("rand d read %h", addr), waited);
            end else begin
                addr[1:0] = 2'b00;
                read_word(1'b1, addr, $sformatf("rand i read %h", addr), waited);
            end
        end
        check_eq("write-through count", 128'(n_writes), 128'(wr_count));

        $display("Checks: %0d, errors: %0d", n_checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
hw/l2_pkg.sv
hw/l2_tag_array.sv
hw/l2_data_array.sv
hw/l2_plru.sv
hw/l2_line_buf.sv
hw/l2_ctrl.sv
hw/hart_l2.sv
tb/tb_clk_gen.sv
tb/tb_hart_l2.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_hart_l2
FILELIST := sources.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run $(TOP) and scan $(LOG) for a failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
